// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // RV32I major opcodes, bits 6..0 of the instruction word
    localparam logic [6:0] opcode_op       = 7'b0110011;
    localparam logic [6:0] opcode_jalr     = 7'b1100111;
    localparam logic [6:0] opcode_load     = 7'b0000011;
    localparam logic [6:0] opcode_op_imm   = 7'b0010011;
    localparam logic [6:0] opcode_misc_mem = 7'b0001111;
    localparam logic [6:0] opcode_system   = 7'b1110011;
    localparam logic [6:0] opcode_store    = 7'b0100011;
    localparam logic [6:0] opcode_branch   = 7'b1100011;
    localparam logic [6:0] opcode_lui      = 7'b0110111;
    localparam logic [6:0] opcode_auipc    = 7'b0010111;
    localparam logic [6:0] opcode_jal      = 7'b1101111;

    // Instruction formats
    // fmt_none marks an opcode this front end does not support
    typedef enum logic [2:0] {
        fmt_r    = 3'd0,
        fmt_i    = 3'd1,
        fmt_s    = 3'd2,
        fmt_b    = 3'd3,
        fmt_u    = 3'd4,
        fmt_j    = 3'd5,
        fmt_none = 3'd7
    } rv_format_e;

    // Register view, also the field layout of I type
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_view_t;

    // Store view, shared with branch
    // imm_hi is bits 31..25 and imm_lo is bits 11..7
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_s_view_t;

    // One word, two decodings
    typedef union packed {
        rv_r_view_t r;
        rv_s_view_t s;
    } rv_instr_u;

endpackage

`default_nettype wire

// File: hdl/decode_pipe_pkg.sv
`default_nettype none

package decode_pipe_pkg;

    // Fetched instruction with its program counter
    typedef struct packed {
        logic [31:0]          pc;
        rv_isa_pkg::rv_instr_u instr;
    } fetch_t;

    // Stage 1 result, all immediate candidates still present
    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
    } decode_1st_t;

    // Stage 2 result towards the scheduler
    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm;
    } decode_2nd_t;

endpackage

`default_nettype wire

// File: hdl/decode_1st.sv
`default_nettype none

module decode_1st (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    input  decode_pipe_pkg::fetch_t fetch,
    output decode_pipe_pkg::decode_1st_t stage_out
);

    decode_pipe_pkg::fetch_t fetch_q;

    logic [31:0] word;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // Flush beats stall
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            fetch_q <= '0;
        end else if (!stall) begin
            fetch_q <= fetch;
        end
    end

    assign word = fetch_q.instr;

    // I type, bits 31..20
    assign imm_i = {{20{word[31]}}, word[31:20]};

    // S type from the two split halves
    assign imm_s = {
        {20{fetch_q.instr.s.imm_hi[6]}},
        fetch_q.instr.s.imm_hi,
        fetch_q.instr.s.imm_lo
    };

    // B type reuses the S halves in scrambled order
    // imm_lo[0] carries bit 11, imm_hi[6] carries bit 12
    assign imm_b = {
        {19{fetch_q.instr.s.imm_hi[6]}},
        fetch_q.instr.s.imm_hi[6],
        fetch_q.instr.s.imm_lo[0],
        fetch_q.instr.s.imm_hi[5:0],
        fetch_q.instr.s.imm_lo[4:1],
        1'b0
    };

    // U type, upper twenty bits
    assign imm_u = {word[31:12], 12'b0};

    // J type, bit order 20 | 10:1 | 11 | 19:12 in the word
    assign imm_j = {
        {11{word[31]}},
        word[31],
        word[19:12],
        word[20],
        word[30:21],
        1'b0
    };

    always_comb begin
        stage_out.pc     = fetch_q.pc;
        stage_out.opcode = fetch_q.instr.r.opcode;
        stage_out.rd     = fetch_q.instr.r.rd;
        stage_out.rs1    = fetch_q.instr.r.rs1;
        stage_out.rs2    = fetch_q.instr.r.rs2;
        stage_out.funct3 = fetch_q.instr.r.funct3;
        stage_out.funct7 = fetch_q.instr.r.funct7;
        stage_out.imm_i  = imm_i;
        stage_out.imm_s  = imm_s;
        stage_out.imm_b  = imm_b;
        stage_out.imm_u  = imm_u;
        stage_out.imm_j  = imm_j;
    end

endmodule

`default_nettype wire

// File: hdl/decode_2nd.sv
`default_nettype none

module decode_2nd (
    input  logic                        CLK,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        flush,
    input  decode_pipe_pkg::decode_1st_t stage_in,
    output decode_pipe_pkg::decode_2nd_t decoded
);

    decode_pipe_pkg::decode_1st_t stage_q;
    rv_isa_pkg::rv_format_e       fmt;
    logic [31:0]                  imm;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            stage_q <= '0;
        end else if (!stall) begin
            stage_q <= stage_in;
        end
    end

    // Format from the opcode alone
    always_comb begin
        case (stage_q.opcode)
            rv_isa_pkg::opcode_op:
                fmt = rv_isa_pkg::fmt_r;
            rv_isa_pkg::opcode_jalr,
            rv_isa_pkg::opcode_load,
            rv_isa_pkg::opcode_op_imm,
            rv_isa_pkg::opcode_misc_mem,
            rv_isa_pkg::opcode_system:
                fmt = rv_isa_pkg::fmt_i;
            rv_isa_pkg::opcode_store:
                fmt = rv_isa_pkg::fmt_s;
            rv_isa_pkg::opcode_branch:
                fmt = rv_isa_pkg::fmt_b;
            rv_isa_pkg::opcode_lui,
            rv_isa_pkg::opcode_auipc:
                fmt = rv_isa_pkg::fmt_u;
            rv_isa_pkg::opcode_jal:
                fmt = rv_isa_pkg::fmt_j;
            default:
                fmt = rv_isa_pkg::fmt_none;
        endcase
    end

    // R type and unsupported opcodes carry no immediate
    always_comb begin
        case (fmt)
            rv_isa_pkg::fmt_i: imm = stage_q.imm_i;
            rv_isa_pkg::fmt_s: imm = stage_q.imm_s;
            rv_isa_pkg::fmt_b: imm = stage_q.imm_b;
            rv_isa_pkg::fmt_u: imm = stage_q.imm_u;
            rv_isa_pkg::fmt_j: imm = stage_q.imm_j;
            default:           imm = '0;
        endcase
    end

    always_comb begin
        decoded.pc     = stage_q.pc;
        decoded.opcode = stage_q.opcode;
        decoded.rd     = stage_q.rd;
        decoded.rs1    = stage_q.rs1;
        decoded.rs2    = stage_q.rs2;
        decoded.funct3 = stage_q.funct3;
        decoded.funct7 = stage_q.funct7;
        decoded.imm    = imm;
    end

endmodule

`default_nettype wire

// File: hdl/decode_frontend.sv
`default_nettype none

module decode_frontend (
    input  logic                        CLK,
    input  logic                        rst,
    input  logic                        STALL,
    input  logic                        FLUSH,
    input  decode_pipe_pkg::fetch_t      fetch,
    output decode_pipe_pkg::decode_2nd_t decoded
);

    // Between the two stages
    decode_pipe_pkg::decode_1st_t stage1;

    // Field split and immediate candidates
    decode_1st decode_1st_i (
        .CLK       (CLK),
        .rst       (rst),
        .stall     (STALL),
        .flush     (FLUSH),
        .fetch     (fetch),
        .stage_out (stage1)
    );

    // Immediate select by format
    decode_2nd decode_2nd_i (
        .CLK      (CLK),
        .rst      (rst),
        .stall    (STALL),
        .flush    (FLUSH),
        .stage_in (stage1),
        .decoded  (decoded)
    );

endmodule

`default_nettype wire

// File: tests/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

`default_nettype none

// Instruction format of each RV32I major opcode
function automatic rv_isa_pkg::rv_format_e format_of(input logic [6:0] opcode);
    rv_isa_pkg::rv_format_e fmt;
    fmt = rv_isa_pkg::fmt_none;
    if (opcode == rv_isa_pkg::opcode_op) begin
        fmt = rv_isa_pkg::fmt_r;
    end else if (opcode == rv_isa_pkg::opcode_jalr || opcode == rv_isa_pkg::opcode_load ||
                 opcode == rv_isa_pkg::opcode_op_imm ||
                 opcode == rv_isa_pkg::opcode_misc_mem ||
                 opcode == rv_isa_pkg::opcode_system) begin
        fmt = rv_isa_pkg::fmt_i;
    end else if (opcode == rv_isa_pkg::opcode_store) begin
        fmt = rv_isa_pkg::fmt_s;
    end else if (opcode == rv_isa_pkg::opcode_branch) begin
        fmt = rv_isa_pkg::fmt_b;
    end else if (opcode == rv_isa_pkg::opcode_lui || opcode == rv_isa_pkg::opcode_auipc) begin
        fmt = rv_isa_pkg::fmt_u;
    end else if (opcode == rv_isa_pkg::opcode_jal) begin
        fmt = rv_isa_pkg::fmt_j;
    end
    return fmt;
endfunction

// Sign-extended immediate, bit layouts as in the RV32I spec
function automatic logic [31:0] immediate_of(input logic [31:0] w,
                                             input rv_isa_pkg::rv_format_e fmt);
    logic [31:0] imm;
    case (fmt)
        rv_isa_pkg::fmt_i: imm = {{21{w[31]}}, w[30:20]};
        rv_isa_pkg::fmt_s: imm = {{21{w[31]}}, w[30:25], w[11:7]};
        rv_isa_pkg::fmt_b: imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        rv_isa_pkg::fmt_u: imm = {w[31:12], 12'h000};
        rv_isa_pkg::fmt_j: imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default:           imm = 32'h0000_0000;
    endcase
    return imm;
endfunction

// What the scheduler should see for one fetched word
function automatic decode_pipe_pkg::decode_2nd_t expected_decode(
    input decode_pipe_pkg::fetch_t f
);
    decode_pipe_pkg::decode_2nd_t d;
    logic [31:0] w;
    w        = f.instr;
    d.pc     = f.pc;
    d.opcode = w[6:0];
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.funct7 = w[31:25];
    d.imm    = immediate_of(w, format_of(w[6:0]));
    return d;
endfunction

`default_nettype wire

`endif

// File: tests/decode_frontend_tb.sv
`include "decode_ref_model.svh"
`default_nettype none

module decode_frontend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 40;
    localparam int n_random     = 300;
    // Reset, directed, zero-imm, drain, random with worst-case stalls, flushes, tail
    localparam int stim_cycles  = 2 + 11 + 3 + 2 + n_random * 4 + 2 * 2 + 12;
    localparam int timeout_ns   = (stim_cycles + 20) * clk_period;

    logic                         CLK;
    logic                         rst;
    logic                         STALL;
    logic                         FLUSH;
    decode_pipe_pkg::fetch_t      fetch;
    decode_pipe_pkg::decode_2nd_t decoded;

    // Index 0 models stage 1, index 1 models stage 2
    decode_pipe_pkg::fetch_t      expected_q [0:1];

    int errors;
    int checks;

    decode_frontend decode_frontend_i (
        .CLK     (CLK),
        .rst     (rst),
        .STALL   (STALL),
        .FLUSH   (FLUSH),
        .fetch   (fetch),
        .decoded (decoded)
    );

    initial begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_output(input decode_pipe_pkg::decode_2nd_t exp);
        check_field("decoded.pc", exp.pc, decoded.pc);
        check_field("decoded.opcode", 32'(exp.opcode), 32'(decoded.opcode));
        check_field("decoded.rd", 32'(exp.rd), 32'(decoded.rd));
        check_field("decoded.rs1", 32'(exp.rs1), 32'(decoded.rs1));
        check_field("decoded.rs2", 32'(exp.rs2), 32'(decoded.rs2));
        check_field("decoded.funct3", 32'(exp.funct3), 32'(decoded.funct3));
        check_field("decoded.funct7", 32'(exp.funct7), 32'(decoded.funct7));
        check_field("decoded.imm", exp.imm, decoded.imm);
    endtask

    // Model the two registers at the edge, compare at the falling edge
    initial begin
        expected_q[0] = '0;
        expected_q[1] = '0;
        forever begin
            @(posedge CLK);
            if (rst || FLUSH) begin
                expected_q[0] = '0;
                expected_q[1] = '0;
            end else if (!STALL) begin
                expected_q[1] = expected_q[0];
                expected_q[0] = fetch;
            end
            @(negedge CLK);
            compare_output(expected_decode(expected_q[1]));
        end
    end

    task automatic send(input logic [31:0] pc, input logic [31:0] word);
        @(posedge CLK);
        fetch.pc    <= pc;
        fetch.instr <= word;
        STALL       <= 1'b0;
        FLUSH       <= 1'b0;
    endtask

    task automatic hold_stall(input int cycles);
        repeat (cycles) begin
            @(posedge CLK);
            STALL <= 1'b1;
        end
    endtask

    task automatic flush_pipeline(input logic with_stall);
        @(posedge CLK);
        FLUSH <= 1'b1;
        STALL <= with_stall;
    endtask

    function automatic logic [6:0] supported_opcode(input int sel);
        case (sel)
            0:       return rv_isa_pkg::opcode_op;
            1:       return rv_isa_pkg::opcode_jalr;
            2:       return rv_isa_pkg::opcode_load;
            3:       return rv_isa_pkg::opcode_op_imm;
            4:       return rv_isa_pkg::opcode_misc_mem;
            5:       return rv_isa_pkg::opcode_system;
            6:       return rv_isa_pkg::opcode_store;
            7:       return rv_isa_pkg::opcode_branch;
            8:       return rv_isa_pkg::opcode_lui;
            9:       return rv_isa_pkg::opcode_auipc;
            default: return rv_isa_pkg::opcode_jal;
        endcase
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        if ($urandom_range(3) == 0) begin
            w[6:0] = supported_opcode($urandom_range(10));
        end
        return w;
    endfunction

    initial begin
        #(timeout_ns);
        $display("Timeout: the decode stream did not finish within %0d cycles", stim_cycles + 20);
        $display("Errors: %0d of %0d checks", errors, checks);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(13207));
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        STALL  = 1'b0;
        FLUSH  = 1'b0;
        fetch  = '0;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;

        // One word per supported opcode
        send(32'h0000_1000, 32'h1234_52B7);  // lui x5, 0x12345
        send(32'h0000_1004, 32'hFFFF_F517);  // auipc with all-ones upper
        send(32'h0000_1008, 32'hFFDF_F0EF);  // jal ra, -4
        send(32'h0000_100C, 32'hFF81_00E7);  // jalr x1, -8(x2)
        send(32'h0000_1010, 32'hFF43_A303);  // lw x6, -12(x7)
        send(32'h0000_1014, 32'h7FF1_0093);  // addi x1, x2, 2047
        send(32'h0000_1018, 32'h0FF0_000F);  // fence
        send(32'h0000_101C, 32'h8001_1173);  // csrrw with imm 0x800
        send(32'h0000_1020, 32'hFE53_2623);  // sw x5, -20(x6)
        send(32'h0000_1024, 32'hFE20_88E3);  // beq x1, x2, -16
        send(32'h0000_1028, 32'h4020_81B3);  // sub x3, x1, x2

        // No immediate expected
        send(32'h0000_102C, 32'hFFFF_FFB3);  // R type with ones everywhere
        send(32'h0000_1030, 32'hFFFF_FF80);  // opcode 0
        send(32'h0000_1034, 32'hABCD_E08B);  // custom-0
        send(32'h0000_0000, 32'h0000_0000);
        send(32'h0000_0000, 32'h0000_0000);

        // Back-to-back stream with stall pulses and two flushes
        for (int i = 0; i < n_random; i++) begin
            send($urandom & 32'hFFFF_FFFC, random_word());
            if ($urandom_range(7) == 0) begin
                hold_stall($urandom_range(3, 1));
            end
            if (i == 100) begin
                flush_pipeline(1'b0);
            end
            if (i == 200) begin
                flush_pipeline(1'b1);
            end
        end

        // Flush under stall, then words after it
        send(32'h0000_2000, 32'hFE53_2623);
        send(32'h0000_2004, 32'hFFDF_F0EF);
        hold_stall(1);
        flush_pipeline(1'b1);
        send(32'h0000_2008, 32'hFE20_8863);
        send(32'h0000_200C, 32'h1234_52B7);
        repeat (3) send(32'h0000_0000, 32'h0000_0000);
        @(posedge CLK);
        @(negedge CLK);

        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+tests
hdl/rv_isa_pkg.sv
hdl/decode_pipe_pkg.sv
hdl/decode_1st.sv
hdl/decode_2nd.sv
hdl/decode_frontend.sv
tests/decode_frontend_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = decode_frontend_tb
FILELIST   = project.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
PASS_MSG   = Testbench passed

.PHONY: all lint build sim clean

all: sim

# Lint the testbench top together with the whole RTL
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
